// ==== barrel_pkg.sv ====
// Shared types and constants for the barrel sprite subsystem.
// Each module imports this package inside its body and names its types
// with barrel_pkg:: in its port list.

`default_nettype none

package barrel_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef logic [10:0] coord_t;
    typedef logic [11:0] rgb_t;

    // row in the upper five bits, column in the lower five.
    typedef logic [9:0] sprite_addr_t;

    // one pixel of the video stream, 38 bits.
    typedef struct packed {
        coord_t hcount;
        coord_t vcount;
        logic   hsync;
        logic   vsync;
        logic   hblnk;
        logic   vblnk;
        rgb_t   rgb;
    } vga_t;

    typedef enum logic [1:0] {
        GS_IDLE,
        GS_ANIM,
        GS_PLAY
    } game_state_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sprite and colours
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int BARREL_WIDTH  = 32;
    localparam int BARREL_HEIGHT = 32;

    localparam rgb_t BLANK_RGB       = 12'h888;
    localparam rgb_t BG_RGB          = 12'h46F;
    localparam rgb_t TRANSPARENT_RGB = 12'h000;
    localparam rgb_t WOOD_RGB        = 12'hA52;
    localparam rgb_t WOOD_DARK_RGB   = 12'h731;
    localparam rgb_t HOOP_RGB        = 12'h666;

    localparam int MAX_BARRELS = 16;

    // start positions, four diagonal rows of four.
    localparam coord_t BARREL_X0 [MAX_BARRELS] = '{
        11'd8,  11'd24, 11'd40, 11'd56,
        11'd16, 11'd32, 11'd48, 11'd64,
        11'd24, 11'd40, 11'd56, 11'd72,
        11'd32, 11'd48, 11'd64, 11'd80
    };
    localparam coord_t BARREL_Y0 [MAX_BARRELS] = '{
        11'd4,  11'd16, 11'd28, 11'd40,
        11'd8,  11'd20, 11'd32, 11'd44,
        11'd12, 11'd24, 11'd36, 11'd48,
        11'd16, 11'd28, 11'd40, 11'd52
    };

endpackage

`default_nettype wire

// ==== vga_timing.sv ====
// Scan position generator for the pixel stream.
// Counts across H_TOTAL x V_TOTAL, derives sync and blank, fills in the
// background colour and flags the start of vertical blanking.

`timescale 1ns/1ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_TOTAL  = 800,
    parameter int V_ACTIVE = 480,
    parameter int V_TOTAL  = 525
) (
    input  logic             clk,
    input  logic             rst,
    output barrel_pkg::vga_t vga,
    output logic             frame_end
);

    import barrel_pkg::*;

    // sync sits in the middle half of each blanking interval.
    localparam int H_BLANK      = H_TOTAL - H_ACTIVE;
    localparam int H_SYNC_START = H_ACTIVE + H_BLANK / 4;
    localparam int H_SYNC_END   = H_SYNC_START + H_BLANK / 2;
    localparam int V_BLANK      = V_TOTAL - V_ACTIVE;
    localparam int V_SYNC_START = V_ACTIVE + V_BLANK / 4;
    localparam int V_SYNC_END   = V_SYNC_START + V_BLANK / 2;

    coord_t h_nxt;
    coord_t v_nxt;
    vga_t   vga_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // next position
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        h_nxt = vga.hcount + coord_t'(1);
        v_nxt = vga.vcount;
        if (vga.hcount == coord_t'(H_TOTAL - 1)) begin
            h_nxt = '0;
            if (vga.vcount == coord_t'(V_TOTAL - 1)) begin
                v_nxt = '0;
            end else begin
                v_nxt = vga.vcount + coord_t'(1);
            end
        end
    end

    always_comb begin
        vga_nxt.hcount = h_nxt;
        vga_nxt.vcount = v_nxt;
        vga_nxt.hblnk  = (h_nxt >= coord_t'(H_ACTIVE));
        vga_nxt.vblnk  = (v_nxt >= coord_t'(V_ACTIVE));
        vga_nxt.hsync  = (h_nxt >= coord_t'(H_SYNC_START)) && (h_nxt < coord_t'(H_SYNC_END));
        vga_nxt.vsync  = (v_nxt >= coord_t'(V_SYNC_START)) && (v_nxt < coord_t'(V_SYNC_END));
        vga_nxt.rgb    = (vga_nxt.hblnk || vga_nxt.vblnk) ? BLANK_RGB : BG_RGB;
    end

    // the output register doubles as the position counter.
    always_ff @(posedge clk) begin
        if (rst) begin
            vga       <= '0;
            vga.rgb   <= BG_RGB;
            frame_end <= 1'b0;
        end else begin
            vga       <= vga_nxt;
            frame_end <= (h_nxt == '0) && (v_nxt == coord_t'(V_ACTIVE));
        end
    end

    a_hcount_range: assert property (@(posedge clk) disable iff (rst)
        vga.hcount < coord_t'(H_TOTAL));

endmodule

`default_nettype wire

// ==== game_fsm.sv ====
// Game flow controller: idle until start, a timed intro, then play.
// The intro length is counted in frame_end pulses.

`timescale 1ns/1ps
`default_nettype none

module game_fsm #(
    parameter int ANIM_FRAMES = 60
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  logic                    frame_end,
    output barrel_pkg::game_state_t state
);

    import barrel_pkg::*;

    localparam int CW = $clog2(ANIM_FRAMES + 1);

    game_state_t   state_nxt;
    logic [CW-1:0] frame_cnt;
    logic          anim_done;

    assign anim_done = frame_end && (frame_cnt == CW'(ANIM_FRAMES - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            GS_IDLE: begin
                if (start) begin
                    state_nxt = GS_ANIM;
                end
            end
            GS_ANIM: begin
                if (anim_done) begin
                    state_nxt = GS_PLAY;
                end
            end
            GS_PLAY: state_nxt = GS_PLAY;
            default: state_nxt = GS_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= GS_IDLE;
            frame_cnt <= '0;
        end else begin
            state <= state_nxt;
            // counts only while the intro runs.
            if (state != GS_ANIM) begin
                frame_cnt <= '0;
            end else if (frame_end) begin
                frame_cnt <= frame_cnt + CW'(1);
            end
        end
    end

    a_play_sticky: assert property (@(posedge clk) disable iff (rst)
        state == GS_PLAY |=> state == GS_PLAY);

endmodule

`default_nettype wire

// ==== barrel_mover.sv ====
// Position registers for all barrels.
// Outside play they hold the start tables; in play every frame_end moves
// each barrel right by STEP, wrapping at H_ACTIVE. BARRELS is at most 16.

`timescale 1ns/1ps
`default_nettype none

module barrel_mover #(
    parameter int BARRELS  = 4,
    parameter int H_ACTIVE = 640,
    parameter int STEP     = 2
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  barrel_pkg::game_state_t              state,
    input  logic                                 frame_end,
    output barrel_pkg::coord_t [BARRELS-1:0]     xpos,
    output barrel_pkg::coord_t [BARRELS-1:0]     ypos
);

    import barrel_pkg::*;

    coord_t [BARRELS-1:0] x_step;
    logic   [11:0]        x_sum;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // advance with wrap
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one extra bit so the sum cannot overflow before the wrap test.
    always_comb begin
        x_sum = '0;
        for (int i = 0; i < BARRELS; i++) begin
            x_sum = {1'b0, xpos[i]} + 12'(STEP);
            if (x_sum >= 12'(H_ACTIVE)) begin
                x_sum = x_sum - 12'(H_ACTIVE);
            end
            x_step[i] = x_sum[10:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || (state != GS_PLAY)) begin
            for (int i = 0; i < BARRELS; i++) begin
                xpos[i] <= BARREL_X0[i];
                ypos[i] <= BARREL_Y0[i];
            end
        end else if (frame_end) begin
            xpos <= x_step;
        end
    end

endmodule

`default_nettype wire

// ==== delay.sv ====
// Fixed-latency shift register for any packed payload.
// dout is din delayed by CLK_DEL clocks; all stages clear on reset.

`timescale 1ns/1ps
`default_nettype none

module delay #(
    parameter int WIDTH   = 38,
    parameter int CLK_DEL = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    logic [WIDTH-1:0] stage [CLK_DEL];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CLK_DEL; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < CLK_DEL; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[CLK_DEL-1];

endmodule

`default_nettype wire

// ==== barrel_rom.sv ====
// 32x32 barrel image, generated from a drawing rule.
// Registered read: rgb follows addr by one clock.

`timescale 1ns/1ps
`default_nettype none

module barrel_rom (
    input  logic                     clk,
    input  barrel_pkg::sprite_addr_t addr,
    output barrel_pkg::rgb_t         rgb
);

    import barrel_pkg::*;

    // side columns transparent, two hoop bands, staves every 8 columns.
    function automatic rgb_t barrel_pixel(input sprite_addr_t a);
        logic [4:0] row;
        logic [4:0] col;
        row = a[9:5];
        col = a[4:0];
        if ((col < 5'd2) || (col > 5'd29)) begin
            return TRANSPARENT_RGB;
        end else if ((row == 5'd4) || (row == 5'd5) || (row == 5'd26) || (row == 5'd27)) begin
            return HOOP_RGB;
        end else if (col[2:0] == 3'd0) begin
            return WOOD_DARK_RGB;
        end
        return WOOD_RGB;
    endfunction

    always_ff @(posedge clk) begin
        rgb <= barrel_pixel(addr);
    end

endmodule

`default_nettype wire

// ==== draw_barrel.sv ====
// Sprite overlay stage on the pixel stream, three clocks of latency.
// Stage 1 registers the hit test and ROM address, stage 2 has the ROM
// pixel and the stream delayed by two, stage 3 registers the mixed colour.

`timescale 1ns/1ps
`default_nettype none

module draw_barrel #(
    parameter int BARRELS = 4
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             show,
    input  logic [BARRELS-1:0]               barrel_en,
    input  barrel_pkg::coord_t [BARRELS-1:0] xpos,
    input  barrel_pkg::coord_t [BARRELS-1:0] ypos,
    input  barrel_pkg::vga_t                 vga_in,
    input  barrel_pkg::rgb_t                 rgb_pixel,
    output barrel_pkg::sprite_addr_t         pixel_addr,
    output barrel_pkg::vga_t                 vga_out
);

    import barrel_pkg::*;

    logic         hit_nxt;
    logic         hit_q;
    logic         hit_q2;
    sprite_addr_t addr_nxt;
    coord_t       dx;
    coord_t       dy;
    vga_t         vga_d2;
    vga_t         vga_nxt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 1: hit test
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // offsets wrap below the box, so one unsigned compare covers both edges.
    // later barrels overwrite earlier ones.
    always_comb begin
        hit_nxt  = 1'b0;
        addr_nxt = pixel_addr;
        dx       = '0;
        dy       = '0;
        for (int i = 0; i < BARRELS; i++) begin
            dx = vga_in.hcount - xpos[i];
            dy = vga_in.vcount - ypos[i];
            if (show && barrel_en[i] &&
                (dx < coord_t'(BARREL_WIDTH)) && (dy < coord_t'(BARREL_HEIGHT))) begin
                hit_nxt  = 1'b1;
                addr_nxt = {dy[4:0], dx[4:0]};
            end
        end
    end

    // stream delayed to line up with the ROM output.
    delay #(
        .WIDTH   ($bits(vga_t)),
        .CLK_DEL (2)
    ) u_delay (
        .clk  (clk),
        .rst  (rst),
        .din  (vga_in),
        .dout (vga_d2)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stage 3: colour mix
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        vga_nxt = vga_d2;
        if (vga_d2.hblnk || vga_d2.vblnk) begin
            vga_nxt.rgb = BLANK_RGB;
        end else if (hit_q2 && (rgb_pixel != TRANSPARENT_RGB)) begin
            vga_nxt.rgb = rgb_pixel;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hit_q      <= 1'b0;
            hit_q2     <= 1'b0;
            pixel_addr <= '0;
            vga_out    <= '0;
        end else begin
            hit_q      <= hit_nxt;
            hit_q2     <= hit_q;
            pixel_addr <= addr_nxt;
            vga_out    <= vga_nxt;
        end
    end

    // the ROM address only moves on a hit.
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        !hit_q |-> $stable(pixel_addr));

endmodule

`default_nettype wire

// ==== barrel_top.sv ====
// Top level of the barrel sprite subsystem.
// Sets frame size, barrel count, intro length and step, and wires the
// timing, game FSM, mover, sprite ROM and drawing stage together.

`timescale 1ns/1ps
`default_nettype none

module barrel_top #(
    parameter int BARRELS     = 4,
    parameter int H_ACTIVE    = 640,
    parameter int H_TOTAL     = 800,
    parameter int V_ACTIVE    = 480,
    parameter int V_TOTAL     = 525,
    parameter int ANIM_FRAMES = 60,
    parameter int STEP        = 2
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  logic [BARRELS-1:0] barrel_en,
    output barrel_pkg::vga_t   vga_out
);

    import barrel_pkg::*;

    vga_t                 vga_bg;
    logic                 frame_end;
    game_state_t          state;
    coord_t [BARRELS-1:0] xpos;
    coord_t [BARRELS-1:0] ypos;
    sprite_addr_t         pixel_addr;
    rgb_t                 rgb_pixel;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_TOTAL  (V_TOTAL)
    ) u_vga_timing (
        .clk       (clk),
        .rst       (rst),
        .vga       (vga_bg),
        .frame_end (frame_end)
    );

    game_fsm #(
        .ANIM_FRAMES (ANIM_FRAMES)
    ) u_game_fsm (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .frame_end (frame_end),
        .state     (state)
    );

    barrel_mover #(
        .BARRELS  (BARRELS),
        .H_ACTIVE (H_ACTIVE),
        .STEP     (STEP)
    ) u_barrel_mover (
        .clk       (clk),
        .rst       (rst),
        .state     (state),
        .frame_end (frame_end),
        .xpos      (xpos),
        .ypos      (ypos)
    );

    barrel_rom u_barrel_rom (
        .clk  (clk),
        .addr (pixel_addr),
        .rgb  (rgb_pixel)
    );

    // sprites are only drawn in play.
    draw_barrel #(
        .BARRELS (BARRELS)
    ) u_draw_barrel (
        .clk        (clk),
        .rst        (rst),
        .show       (state == GS_PLAY),
        .barrel_en  (barrel_en),
        .xpos       (xpos),
        .ypos       (ypos),
        .vga_in     (vga_bg),
        .rgb_pixel  (rgb_pixel),
        .pixel_addr (pixel_addr),
        .vga_out    (vga_out)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
// Clock and reset source for the testbench.
// clk toggles every PERIOD/2 ns; rst is held high for RST_CYCLES rising
// edges and released 1 ns after the last one.

`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== barrel_tb.sv ====
// Testbench for the barrel sprite subsystem on a small frame.
// Checks the intro frames, then applies a table of barrel enables,
// play frame numbers and probe points against a reference model.

`timescale 1ns/1ps
`default_nettype none

module barrel_tb;

    import barrel_pkg::*;

    localparam int H_ACTIVE    = 128;
    localparam int H_TOTAL     = 160;
    localparam int V_ACTIVE    = 96;
    localparam int V_TOTAL     = 104;
    localparam int BARRELS     = 4;
    localparam int ANIM_FRAMES = 2;
    localparam int STEP        = 8;

    localparam int ROWS         = 5;
    localparam int PROBES       = 4;
    localparam int RANDOM_PROBES = 6;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // play frame numbers must rise from row to row.
    int         row_frame [ROWS] = '{0, 1, 3, 6, 12};
    logic [3:0] row_en    [ROWS] = '{4'b1111, 4'b0101, 4'b1010, 4'b1111, 4'b1001};
    int probe_h [ROWS][PROBES] = '{
        '{30, 26, 10, 60},
        '{38, 34, 18, 70},
        '{50, 40, 30, 80},
        '{80, 90, 100, 110},
        '{20, 120, 125, 5}
    };
    int probe_v [ROWS][PROBES] = '{
        '{20, 30, 10, 50},
        '{20, 30, 10, 50},
        '{20, 30, 40, 50},
        '{10, 30, 50, 70},
        '{10, 20, 55, 30}
    };

    // frames of the whole run plus a margin, one frame per H_TOTAL*V_TOTAL clocks.
    localparam int WATCH_FRAMES = ANIM_FRAMES + 12 + 1 + 4;
    localparam longint WATCH_NS = longint'(WATCH_FRAMES) * H_TOTAL * V_TOTAL * 10;

    logic               clk;
    logic               rst;
    logic               start;
    logic [BARRELS-1:0] barrel_en;
    vga_t               vga_out;

    int          cur_frame;
    int          test_errors;
    int          test_checks;
    int          total_errors;
    int          tests_passed;
    int          tests_failed;
    logic [15:0] lfsr;
    bit          probe_mark [V_TOTAL][H_TOTAL];
    int          prev_h;
    int          prev_v;
    bit          have_prev;
    bit          hsync_seen;

    tb_clock #(
        .PERIOD     (10),
        .RST_CYCLES (8)
    ) u_clock (
        .clk (clk),
        .rst (rst)
    );

    barrel_top #(
        .BARRELS     (BARRELS),
        .H_ACTIVE    (H_ACTIVE),
        .H_TOTAL     (H_TOTAL),
        .V_ACTIVE    (V_ACTIVE),
        .V_TOTAL     (V_TOTAL),
        .ANIM_FRAMES (ANIM_FRAMES),
        .STEP        (STEP)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .barrel_en (barrel_en),
        .vga_out   (vga_out)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic bit is_blank(input int h, input int v);
        return (h >= H_ACTIVE) || (v >= V_ACTIVE);
    endfunction

    function automatic rgb_t sprite_color(input int row, input int col);
        if (col < 2 || col > 29) begin
            return TRANSPARENT_RGB;
        end
        if (row == 4 || row == 5 || row == 26 || row == 27) begin
            return HOOP_RGB;
        end
        if (col % 8 == 0) begin
            return WOOD_DARK_RGB;
        end
        return WOOD_RGB;
    endfunction

    // x position after k frames of play, wrapped at the active width.
    function automatic int barrel_x(input int i, input int k);
        return (int'(BARREL_X0[i]) + STEP * k) % H_ACTIVE;
    endfunction

    function automatic rgb_t expected_rgb(input int h, input int v,
                                          input logic [3:0] en, input int k);
        bit   hit;
        rgb_t c;
        int   dx;
        int   dy;
        hit = 0;
        c   = BG_RGB;
        if (h >= H_ACTIVE || v >= V_ACTIVE) begin
            return BLANK_RGB;
        end
        for (int i = 0; i < BARRELS; i++) begin
            dx = h - barrel_x(i, k);
            dy = v - int'(BARREL_Y0[i]);
            if (en[i] && dx >= 0 && dx < 32 && dy >= 0 && dy < 32) begin
                hit = 1;
                c   = sprite_color(dy, dx);
            end
        end
        if (!hit || c == TRANSPARENT_RGB) begin
            return BG_RGB;
        end
        return c;
    endfunction

    // galois lfsr, one step per bit taken.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            val  = (val << 1) | int'(lfsr[0]);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compare_coord(input string name, input coord_t got, input coord_t exp);
        test_checks++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        test_checks++;
        if (got !== exp) begin
            $display("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp);
            test_errors++;
        end
    endtask

    // sample the output mid-cycle; count output frames at position 0,0.
    // the position steps one pixel per clock, blank follows the position
    // and sync only ever sits inside blanking.
    task automatic next_pixel();
        int exp_h;
        int exp_v;
        @(negedge clk);
        if (have_prev) begin
            exp_h = (prev_h + 1) % H_TOTAL;
            exp_v = (exp_h == 0) ? (prev_v + 1) % V_TOTAL : prev_v;
            compare_coord("vga_out.hcount", vga_out.hcount, coord_t'(exp_h));
            compare_coord("vga_out.vcount", vga_out.vcount, coord_t'(exp_v));
        end
        compare_flag("vga_out.hblnk", vga_out.hblnk, vga_out.hcount >= coord_t'(H_ACTIVE));
        compare_flag("vga_out.vblnk", vga_out.vblnk, vga_out.vcount >= coord_t'(V_ACTIVE));
        if (vga_out.hsync && vga_out.hcount < coord_t'(H_ACTIVE)) begin
            $display("t=%0t hsync is high inside the active line at (%0d,%0d)",
                     $time, vga_out.hcount, vga_out.vcount);
            test_errors++;
        end
        if (vga_out.vsync && vga_out.vcount < coord_t'(V_ACTIVE)) begin
            $display("t=%0t vsync is high inside the active frame at (%0d,%0d)",
                     $time, vga_out.hcount, vga_out.vcount);
            test_errors++;
        end
        if (have_prev && vga_out.hcount == 0) begin
            test_checks++;
            if (!hsync_seen) begin
                $display("t=%0t no hsync pulse in the line before (%0d,%0d)",
                         $time, vga_out.hcount, vga_out.vcount);
                test_errors++;
            end
            hsync_seen = 0;
        end
        if (vga_out.hsync) begin
            hsync_seen = 1;
        end
        prev_h    = int'(vga_out.hcount);
        prev_v    = int'(vga_out.vcount);
        have_prev = 1;
        if (vga_out.hcount == 0 && vga_out.vcount == 0) begin
            cur_frame++;
        end
    endtask

    task automatic compare_rgb(input rgb_t exp);
        test_checks++;
        if (vga_out.rgb !== exp) begin
            $display("FAIL t=%0t vga_out.rgb at (%0d,%0d): got %h expected %h",
                     $time, vga_out.hcount, vga_out.vcount, vga_out.rgb, exp);
            test_errors++;
        end
    endtask

    task automatic mark_probe(input int h, input int v);
        if (h >= 0 && h < H_TOTAL && v >= 0 && v < V_TOTAL) begin
            probe_mark[v][h] = 1;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-16s %0d checks, %0d errors", name, test_checks, test_errors);
        if (test_errors == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic run_row(input int r);
        int k;
        int bi;
        int dx;
        int dy;
        int x;
        int y;
        k = row_frame[r];
        // wait for the blanking before the target frame, then switch enables.
        while (!(cur_frame == k - 1 && vga_out.vblnk)) begin
            next_pixel();
        end
        @(posedge clk);
        #1 barrel_en = row_en[r];
        for (int v = 0; v < V_TOTAL; v++) begin
            for (int h = 0; h < H_TOTAL; h++) begin
                probe_mark[v][h] = 0;
            end
        end
        for (int p = 0; p < PROBES; p++) begin
            mark_probe(probe_h[r][p], probe_v[r][p]);
        end
        // moved box edges, inside and just outside.
        for (int i = 0; i < BARRELS; i++) begin
            x = barrel_x(i, k);
            y = int'(BARREL_Y0[i]);
            mark_probe(x + 1, y + 8);
            mark_probe(x + 2, y + 8);
            mark_probe(x + 29, y + 20);
            mark_probe(x + 32, y + 20);
            mark_probe(x - 1, y + 12);
        end
        for (int p = 0; p < RANDOM_PROBES; p++) begin
            take_bits(2, bi);
            take_bits(5, dx);
            take_bits(5, dy);
            mark_probe(barrel_x(bi, k) + dx, int'(BARREL_Y0[bi]) + dy);
        end
        do begin
            next_pixel();
            if (cur_frame == k) begin
                if (is_blank(int'(vga_out.hcount), int'(vga_out.vcount)) ||
                    probe_mark[vga_out.vcount][vga_out.hcount]) begin
                    compare_rgb(expected_rgb(int'(vga_out.hcount), int'(vga_out.vcount),
                                             row_en[r], k));
                end
            end
        end while (!(cur_frame == k && vga_out.vblnk));
        finish_test($sformatf("play_frame_%0d", k));
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        int   vsync_count;
        logic vsync_prev;
        start        = 1'b0;
        barrel_en    = '0;
        cur_frame    = -1000;
        test_errors  = 0;
        test_checks  = 0;
        total_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        lfsr         = 16'd59961;
        prev_h       = 0;
        prev_v       = 0;
        have_prev    = 0;
        hsync_seen   = 0;
        vsync_count  = 0;
        vsync_prev   = 1'b0;

        @(negedge rst);
        @(posedge clk);
        #1;
        start     = 1'b1;
        barrel_en = '1;
        @(posedge clk);
        #1 start = 1'b0;
        // let the pipeline fill past its reset contents.
        repeat (6) @(posedge clk);

        // intro: no barrel drawn until ANIM_FRAMES output vsync pulses.
        while (vsync_count < ANIM_FRAMES) begin
            next_pixel();
            if (is_blank(int'(vga_out.hcount), int'(vga_out.vcount))) begin
                compare_rgb(BLANK_RGB);
            end else begin
                compare_rgb(BG_RGB);
            end
            if (vga_out.vsync && !vsync_prev) begin
                vsync_count++;
            end
            vsync_prev = vga_out.vsync;
        end
        finish_test("intro");

        // the next output frame is play frame 0.
        cur_frame = -1;
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end

        $display("tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCH_NS);
        $display("watchdog expired before all tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
barrel_pkg.sv
vga_timing.sv
game_fsm.sv
barrel_mover.sv
delay.sv
barrel_rom.sv
draw_barrel.sv
barrel_top.sv
tb_clock.sv
barrel_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	verilator --binary --timing --assert -f all.f --top-module barrel_tb -o Vbarrel_tb
	@out=$$(./obj_dir/Vbarrel_tb); \
	echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir
